/* verilog/rv_cfg.svh */
/*
 * Widths for the RV32I decode/execute slice.
 * The immediate and shift logic assume XLEN is 32, so these are not free knobs.
 * NUM_REGS must equal 2**REG_AW.
 */

`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// Data and PC width, one word
`define XLEN 32

// Architectural integer registers, x0 included
`define NUM_REGS 32

// Register index width
`define REG_AW 5

`endif

/* verilog/rv_pkg.sv */
/*
 * Shared types for the decode/execute slice.
 * The control word keeps the legacy 12-bit packing. The old data-size
 * bits [11:10] now carry the operand-A select.
 */

`include "rv_cfg.svh"

package rv_pkg;

    typedef logic [`XLEN-1:0]   word_t;
    typedef logic [`REG_AW-1:0] reg_addr_t;
    typedef logic [3:0]         alu_op_t;
    typedef logic [2:0]         br_cond_t;    // Same encoding as funct3
    typedef logic [1:0]         opa_sel_t;

    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_SLL    = 4'd2;
    localparam alu_op_t ALU_SLT    = 4'd3;
    localparam alu_op_t ALU_SLTU   = 4'd4;
    localparam alu_op_t ALU_XOR    = 4'd5;
    localparam alu_op_t ALU_SRL    = 4'd6;
    localparam alu_op_t ALU_SRA    = 4'd7;
    localparam alu_op_t ALU_OR     = 4'd8;
    localparam alu_op_t ALU_AND    = 4'd9;
    localparam alu_op_t ALU_PASS_B = 4'd10;

    localparam br_cond_t BR_BEQ  = 3'b000;
    localparam br_cond_t BR_BNE  = 3'b001;
    localparam br_cond_t BR_BLT  = 3'b100;
    localparam br_cond_t BR_BGE  = 3'b101;
    localparam br_cond_t BR_BLTU = 3'b110;
    localparam br_cond_t BR_BGEU = 3'b111;

    localparam opa_sel_t OPA_RS1  = 2'd0;
    localparam opa_sel_t OPA_PC   = 2'd1;
    localparam opa_sel_t OPA_ZERO = 2'd2;

    typedef struct packed {
        opa_sel_t opa_sel;      // [11:10]
        logic     rsvd;         // [9] unused by this slice
        logic     jalr;         // [8]
        logic     link;         // [7] writes pc + 4
        logic     jump;         // [6]
        logic     branch;       // [5]
        logic     mem_to_reg;   // [4]
        logic     alu_src_imm;  // [3]
        logic     mem_write;    // [2]
        logic     mem_read;     // [1]
        logic     reg_write;    // [0]
    } ctrl_t;

endpackage

/* verilog/reg_file.sv */
/*
 * Integer register file with two read ports and one write port.
 * Reads are write-first, so a same-cycle write is visible on the read ports.
 * x0 reads as zero and ignores writes.
 */

`timescale 1ns/1ns

`include "rv_cfg.svh"

module reg_file (
    input  logic              clk,
    input  logic              i_arst_n,
    input  rv_pkg::reg_addr_t i_rs1_addr,
    input  rv_pkg::reg_addr_t i_rs2_addr,
    input  logic              i_wr_en,
    input  rv_pkg::reg_addr_t i_wr_addr,
    input  rv_pkg::word_t     i_wr_data,
    output rv_pkg::word_t     o_rs1_data,
    output rv_pkg::word_t     o_rs2_data
);

    rv_pkg::word_t regs [`NUM_REGS];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && i_wr_addr != '0) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // Bypass the write data when reading the address being written
    assign o_rs1_data = (i_rs1_addr == '0) ? '0 :
                        (i_wr_en && i_wr_addr == i_rs1_addr) ? i_wr_data : regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == '0) ? '0 :
                        (i_wr_en && i_wr_addr == i_rs2_addr) ? i_wr_data : regs[i_rs2_addr];

    a_x0_stays_zero : assert property (
        @(posedge clk) disable iff (!i_arst_n)
        (i_wr_en && i_wr_addr == '0) |=> $stable(regs[0]) && regs[0] == '0
    ) else $error("x0 changed after a write to address 0");

endmodule

/* verilog/instr_decoder.sv */
/*
 * RV32I decoder for the ALU, branch and jump subset.
 * Loads, stores, system and unknown opcodes decode to a bubble (all-zero control).
 * Immediates are built for 32-bit words only.
 */

`timescale 1ns/1ns

`include "rv_cfg.svh"

module instr_decoder (
    input  logic              i_valid,
    input  rv_pkg::word_t     i_instr,
    input  rv_pkg::word_t     i_pc,
    output rv_pkg::ctrl_t     o_ctrl,
    output rv_pkg::alu_op_t   o_alu_op,
    output rv_pkg::word_t     o_imm,
    output rv_pkg::reg_addr_t o_rs1_addr,
    output rv_pkg::reg_addr_t o_rs2_addr,
    output rv_pkg::reg_addr_t o_rd_addr,
    output rv_pkg::br_cond_t  o_func3,
    output rv_pkg::word_t     o_pc,
    output rv_pkg::word_t     o_pc_next
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            f7_b5;
    rv_pkg::alu_op_t arith_op;
    rv_pkg::word_t   imm_i;
    rv_pkg::word_t   imm_s;
    rv_pkg::word_t   imm_b;
    rv_pkg::word_t   imm_u;
    rv_pkg::word_t   imm_j;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign f7_b5  = i_instr[30];      // SUB and SRA select

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};

    // Shared by OP and OP-IMM, funct7 only splits ADD/SUB for register ops
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == OPC_OP && f7_b5) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  arith_op = rv_pkg::ALU_SLL;
            3'b010:  arith_op = rv_pkg::ALU_SLT;
            3'b011:  arith_op = rv_pkg::ALU_SLTU;
            3'b100:  arith_op = rv_pkg::ALU_XOR;
            3'b101:  arith_op = f7_b5 ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  arith_op = rv_pkg::ALU_OR;
            default: arith_op = rv_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        o_ctrl   = '0;
        o_alu_op = rv_pkg::ALU_ADD;
        o_imm    = imm_i;
        if (i_valid) begin
            case (opcode)
                OPC_OP: begin
                    o_ctrl.reg_write = 1'b1;
                    o_alu_op         = arith_op;
                end
                OPC_OP_IMM: begin
                    o_ctrl.reg_write   = 1'b1;
                    o_ctrl.alu_src_imm = 1'b1;
                    o_alu_op           = arith_op;
                end
                OPC_LUI: begin
                    o_ctrl.reg_write   = 1'b1;
                    o_ctrl.alu_src_imm = 1'b1;
                    o_ctrl.opa_sel     = rv_pkg::OPA_ZERO;
                    o_alu_op           = rv_pkg::ALU_PASS_B;
                    o_imm              = imm_u;
                end
                OPC_AUIPC: begin
                    o_ctrl.reg_write   = 1'b1;
                    o_ctrl.alu_src_imm = 1'b1;
                    o_ctrl.opa_sel     = rv_pkg::OPA_PC;
                    o_imm              = imm_u;
                end
                OPC_BRANCH: begin
                    o_ctrl.branch = (funct3 != 3'b010) && (funct3 != 3'b011);
                    o_imm         = imm_b;
                end
                OPC_JAL: begin
                    o_ctrl.reg_write = 1'b1;
                    o_ctrl.jump      = 1'b1;
                    o_ctrl.link      = 1'b1;
                    o_imm            = imm_j;
                end
                OPC_JALR: begin
                    o_ctrl.reg_write = 1'b1;
                    o_ctrl.jump      = 1'b1;
                    o_ctrl.link      = 1'b1;
                    o_ctrl.jalr      = 1'b1;
                end
                OPC_STORE: o_imm = imm_s;   // No data memory, still a bubble
                default: ;
            endcase
        end
    end

    assign o_rs1_addr = i_instr[19:15];
    assign o_rs2_addr = i_instr[24:20];
    assign o_rd_addr  = i_instr[11:7];
    assign o_func3    = funct3;
    assign o_pc       = i_pc;
    assign o_pc_next  = i_pc + `XLEN'd4;

endmodule

/* verilog/id_ex_reg.sv */
/*
 * ID/EX pipeline register.
 * Stall holds every field and wins over flush. Flush and reset clear only
 * the control word; data fields are left as loaded.
 */

`timescale 1ns/1ns

module id_ex_reg (
    input  logic              clk,
    input  logic              i_arst_n,
    input  logic              i_stall,
    input  logic              i_flush,
    input  rv_pkg::ctrl_t     i_ctrl,
    input  rv_pkg::alu_op_t   i_alu_op,
    input  rv_pkg::word_t     i_imm,
    input  rv_pkg::reg_addr_t i_rs1_addr,
    input  rv_pkg::reg_addr_t i_rs2_addr,
    input  rv_pkg::reg_addr_t i_rd_addr,
    input  rv_pkg::br_cond_t  i_func3,
    input  rv_pkg::word_t     i_pc,
    input  rv_pkg::word_t     i_pc_next,
    input  rv_pkg::word_t     i_rs1_data,
    input  rv_pkg::word_t     i_rs2_data,
    output rv_pkg::ctrl_t     o_ctrl,
    output rv_pkg::alu_op_t   o_alu_op,
    output rv_pkg::word_t     o_imm,
    output rv_pkg::reg_addr_t o_rs1_addr,
    output rv_pkg::reg_addr_t o_rs2_addr,
    output rv_pkg::reg_addr_t o_rd_addr,
    output rv_pkg::br_cond_t  o_func3,
    output rv_pkg::word_t     o_pc,
    output rv_pkg::word_t     o_pc_next,
    output rv_pkg::word_t     o_rs1_data,
    output rv_pkg::word_t     o_rs2_data
);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_ctrl <= '0;
        end else if (!i_stall) begin
            o_ctrl <= i_flush ? '0 : i_ctrl;    // Squashed slot becomes a bubble
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            o_alu_op   <= i_alu_op;
            o_imm      <= i_imm;
            o_rs1_addr <= i_rs1_addr;
            o_rs2_addr <= i_rs2_addr;
            o_rd_addr  <= i_rd_addr;
            o_func3    <= i_func3;
            o_pc       <= i_pc;
            o_pc_next  <= i_pc_next;
            o_rs1_data <= i_rs1_data;
            o_rs2_data <= i_rs2_data;
        end
    end

    a_flush_bubble : assert property (
        @(posedge clk) disable iff (!i_arst_n)
        (i_flush && !i_stall) |=> (o_ctrl == '0)
    ) else $error("ID/EX control not cleared after flush");

endmodule

/* verilog/execute_unit.sv */
/*
 * Execute stage: forwarding, ALU, branch/jump resolution and EX/WB register.
 * o_redirect is combinational from the ID/EX contents and is not masked by stall.
 * The register file write port carries the value EX/WB loads on the same edge.
 */

`timescale 1ns/1ns

module execute_unit (
    input  logic              clk,
    input  logic              i_arst_n,
    input  logic              i_stall,
    input  rv_pkg::ctrl_t     i_ctrl,
    input  rv_pkg::alu_op_t   i_alu_op,
    input  rv_pkg::word_t     i_imm,
    input  rv_pkg::reg_addr_t i_rs1_addr,
    input  rv_pkg::reg_addr_t i_rs2_addr,
    input  rv_pkg::reg_addr_t i_rd_addr,
    input  rv_pkg::br_cond_t  i_func3,
    input  rv_pkg::word_t     i_pc,
    input  rv_pkg::word_t     i_pc_next,
    input  rv_pkg::word_t     i_rs1_data,
    input  rv_pkg::word_t     i_rs2_data,
    output logic              o_redirect,
    output rv_pkg::word_t     o_redirect_pc,
    output logic              o_rf_wr_en,
    output rv_pkg::reg_addr_t o_rf_wr_addr,
    output rv_pkg::word_t     o_rf_wr_data,
    output logic              o_wb_valid,
    output rv_pkg::reg_addr_t o_wb_rd,
    output rv_pkg::word_t     o_wb_data
);

    rv_pkg::word_t rs1_val;
    rv_pkg::word_t rs2_val;
    rv_pkg::word_t op_a;
    rv_pkg::word_t op_b;
    rv_pkg::word_t alu_res;
    rv_pkg::word_t tgt_sum;
    logic [4:0]    shamt;
    logic          taken;

    // Forward from EX/WB, wb_valid already excludes x0
    assign rs1_val = (o_wb_valid && o_wb_rd == i_rs1_addr) ? o_wb_data : i_rs1_data;
    assign rs2_val = (o_wb_valid && o_wb_rd == i_rs2_addr) ? o_wb_data : i_rs2_data;

    assign op_a  = (i_ctrl.opa_sel == rv_pkg::OPA_PC)   ? i_pc :
                   (i_ctrl.opa_sel == rv_pkg::OPA_ZERO) ? '0 : rs1_val;
    assign op_b  = i_ctrl.alu_src_imm ? i_imm : rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        case (i_alu_op)
            rv_pkg::ALU_SUB:    alu_res = op_a - op_b;
            rv_pkg::ALU_SLL:    alu_res = op_a << shamt;
            rv_pkg::ALU_SLT:    alu_res = rv_pkg::word_t'($signed(op_a) < $signed(op_b));
            rv_pkg::ALU_SLTU:   alu_res = rv_pkg::word_t'(op_a < op_b);
            rv_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
            rv_pkg::ALU_SRL:    alu_res = op_a >> shamt;
            rv_pkg::ALU_SRA:    alu_res = rv_pkg::word_t'($signed(op_a) >>> shamt);
            rv_pkg::ALU_OR:     alu_res = op_a | op_b;
            rv_pkg::ALU_AND:    alu_res = op_a & op_b;
            rv_pkg::ALU_PASS_B: alu_res = op_b;
            default:            alu_res = op_a + op_b;
        endcase
    end

    always_comb begin
        case (i_func3)
            rv_pkg::BR_BEQ:  taken = (rs1_val == rs2_val);
            rv_pkg::BR_BNE:  taken = (rs1_val != rs2_val);
            rv_pkg::BR_BLT:  taken = ($signed(rs1_val) < $signed(rs2_val));
            rv_pkg::BR_BGE:  taken = ($signed(rs1_val) >= $signed(rs2_val));
            rv_pkg::BR_BLTU: taken = (rs1_val < rs2_val);
            rv_pkg::BR_BGEU: taken = (rs1_val >= rs2_val);
            default:         taken = 1'b0;
        endcase
    end

    assign tgt_sum       = (i_ctrl.jalr ? rs1_val : i_pc) + i_imm;
    assign o_redirect    = i_ctrl.jump || (i_ctrl.branch && taken);
    assign o_redirect_pc = {tgt_sum[31:1], tgt_sum[0] & ~i_ctrl.jalr};    // JALR drops bit 0

    assign o_rf_wr_en   = i_ctrl.reg_write && (i_rd_addr != '0) && !i_stall;
    assign o_rf_wr_addr = i_rd_addr;
    assign o_rf_wr_data = i_ctrl.link ? i_pc_next : alu_res;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_wb_valid <= 1'b0;
        end else if (!i_stall) begin
            o_wb_valid <= o_rf_wr_en;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            o_wb_rd   <= o_rf_wr_addr;
            o_wb_data <= o_rf_wr_data;
        end
    end

    a_wb_not_x0 : assert property (
        @(posedge clk) disable iff (!i_arst_n)
        o_wb_valid |-> (o_wb_rd != '0)
    ) else $error("Write-back reported for x0");

endmodule

/* verilog/decode_execute_top.sv */
/*
 * Decode-to-execute slice of an RV32I pipeline.
 * Fetch must present the instruction at o_redirect_pc in the cycle after
 * o_redirect; the instruction offered during the redirect cycle is dropped.
 */

`timescale 1ns/1ns

module decode_execute_top (
    input  logic              clk,
    input  logic              i_arst_n,
    input  logic              i_valid,
    input  rv_pkg::word_t     i_instr,
    input  rv_pkg::word_t     i_pc,
    input  logic              i_stall,
    output logic              o_redirect,
    output rv_pkg::word_t     o_redirect_pc,
    output logic              o_wb_valid,
    output rv_pkg::reg_addr_t o_wb_rd,
    output rv_pkg::word_t     o_wb_data
);

    // Decode stage
    rv_pkg::ctrl_t     id_ctrl;
    rv_pkg::alu_op_t   id_alu_op;
    rv_pkg::word_t     id_imm;
    rv_pkg::reg_addr_t id_rs1_addr;
    rv_pkg::reg_addr_t id_rs2_addr;
    rv_pkg::reg_addr_t id_rd_addr;
    rv_pkg::br_cond_t  id_func3;
    rv_pkg::word_t     id_pc;
    rv_pkg::word_t     id_pc_next;
    rv_pkg::word_t     id_rs1_data;
    rv_pkg::word_t     id_rs2_data;

    // Execute stage
    rv_pkg::ctrl_t     ex_ctrl;
    rv_pkg::alu_op_t   ex_alu_op;
    rv_pkg::word_t     ex_imm;
    rv_pkg::reg_addr_t ex_rs1_addr;
    rv_pkg::reg_addr_t ex_rs2_addr;
    rv_pkg::reg_addr_t ex_rd_addr;
    rv_pkg::br_cond_t  ex_func3;
    rv_pkg::word_t     ex_pc;
    rv_pkg::word_t     ex_pc_next;
    rv_pkg::word_t     ex_rs1_data;
    rv_pkg::word_t     ex_rs2_data;

    // Register file write port
    logic              rf_wr_en;
    rv_pkg::reg_addr_t rf_wr_addr;
    rv_pkg::word_t     rf_wr_data;

    instr_decoder u_decoder (
        .i_valid    (i_valid),
        .i_instr    (i_instr),
        .i_pc       (i_pc),
        .o_ctrl     (id_ctrl),
        .o_alu_op   (id_alu_op),
        .o_imm      (id_imm),
        .o_rs1_addr (id_rs1_addr),
        .o_rs2_addr (id_rs2_addr),
        .o_rd_addr  (id_rd_addr),
        .o_func3    (id_func3),
        .o_pc       (id_pc),
        .o_pc_next  (id_pc_next)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_rs1_addr (id_rs1_addr),
        .i_rs2_addr (id_rs2_addr),
        .i_wr_en    (rf_wr_en),
        .i_wr_addr  (rf_wr_addr),
        .i_wr_data  (rf_wr_data),
        .o_rs1_data (id_rs1_data),
        .o_rs2_data (id_rs2_data)
    );

    id_ex_reg u_id_ex (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_stall    (i_stall),
        .i_flush    (o_redirect),       // Squash the slot behind a taken redirect
        .i_ctrl     (id_ctrl),
        .i_alu_op   (id_alu_op),
        .i_imm      (id_imm),
        .i_rs1_addr (id_rs1_addr),
        .i_rs2_addr (id_rs2_addr),
        .i_rd_addr  (id_rd_addr),
        .i_func3    (id_func3),
        .i_pc       (id_pc),
        .i_pc_next  (id_pc_next),
        .i_rs1_data (id_rs1_data),
        .i_rs2_data (id_rs2_data),
        .o_ctrl     (ex_ctrl),
        .o_alu_op   (ex_alu_op),
        .o_imm      (ex_imm),
        .o_rs1_addr (ex_rs1_addr),
        .o_rs2_addr (ex_rs2_addr),
        .o_rd_addr  (ex_rd_addr),
        .o_func3    (ex_func3),
        .o_pc       (ex_pc),
        .o_pc_next  (ex_pc_next),
        .o_rs1_data (ex_rs1_data),
        .o_rs2_data (ex_rs2_data)
    );

    execute_unit u_execute (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_stall       (i_stall),
        .i_ctrl        (ex_ctrl),
        .i_alu_op      (ex_alu_op),
        .i_imm         (ex_imm),
        .i_rs1_addr    (ex_rs1_addr),
        .i_rs2_addr    (ex_rs2_addr),
        .i_rd_addr     (ex_rd_addr),
        .i_func3       (ex_func3),
        .i_pc          (ex_pc),
        .i_pc_next     (ex_pc_next),
        .i_rs1_data    (ex_rs1_data),
        .i_rs2_data    (ex_rs2_data),
        .o_redirect    (o_redirect),
        .o_redirect_pc (o_redirect_pc),
        .o_rf_wr_en    (rf_wr_en),
        .o_rf_wr_addr  (rf_wr_addr),
        .o_rf_wr_data  (rf_wr_data),
        .o_wb_valid    (o_wb_valid),
        .o_wb_rd       (o_wb_rd),
        .o_wb_data     (o_wb_data)
    );

endmodule

/* dv/tb_program_table.svh */
/*
 * Program for the decode/execute testbench, one row per word from pc 0.
 * Columns: index, name, instruction, writes back, rd, value, redirects, target, forced stall.
 * Rows 7, 9 and 17 sit behind a redirect and are squashed; row 18 is skipped.
 */

task automatic load_program_table();
    set_row(0,  "addi",  32'h00500093, 1'b1, 5'd1,  32'h00000005, 1'b0, 32'h0,  1'b0);
    set_row(1,  "xori",  32'h80004113, 1'b1, 5'd2,  32'hfffff800, 1'b0, 32'h0,  1'b0);
    set_row(2,  "slti",  32'h00102193, 1'b1, 5'd3,  32'h00000001, 1'b0, 32'h0,  1'b0);
    set_row(3,  "srai",  32'h40415213, 1'b1, 5'd4,  32'hffffff80, 1'b0, 32'h0,  1'b0);
    // Previous result, then one from two rows back
    set_row(4,  "add",   32'h001202b3, 1'b1, 5'd5,  32'hffffff85, 1'b0, 32'h0,  1'b0);
    set_row(5,  "add",   32'h00520333, 1'b1, 5'd6,  32'hffffff05, 1'b0, 32'h0,  1'b1);
    set_row(6,  "beq",   32'h00108463, 1'b0, 5'd0,  32'h00000000, 1'b1, 32'd32, 1'b0);
    set_row(7,  "addi",  32'h06300393, 1'b1, 5'd7,  32'h00000063, 1'b0, 32'h0,  1'b0);
    set_row(8,  "jal",   32'h0080046f, 1'b1, 5'd8,  32'h00000024, 1'b1, 32'd40, 1'b0);
    set_row(9,  "addi",  32'h04d00493, 1'b1, 5'd9,  32'h0000004d, 1'b0, 32'h0,  1'b0);
    set_row(10, "bne",   32'h00109463, 1'b0, 5'd0,  32'h00000000, 1'b0, 32'h0,  1'b0);
    // Write to x0, then read it back
    set_row(11, "addi",  32'h00500013, 1'b0, 5'd0,  32'h00000000, 1'b0, 32'h0,  1'b0);
    set_row(12, "add",   32'h00000533, 1'b1, 5'd10, 32'h00000000, 1'b0, 32'h0,  1'b0);
    set_row(13, "lui",   32'h123455b7, 1'b1, 5'd11, 32'h12345000, 1'b0, 32'h0,  1'b1);
    set_row(14, "auipc", 32'h00001617, 1'b1, 5'd12, 32'h00001038, 1'b0, 32'h0,  1'b0);
    set_row(15, "sub",   32'h401586b3, 1'b1, 5'd13, 32'h12344ffb, 1'b0, 32'h0,  1'b0);
    set_row(16, "jalr",  32'h04808767, 1'b1, 5'd14, 32'h00000044, 1'b1, 32'd76, 1'b0);
    set_row(17, "addi",  32'h00100793, 1'b1, 5'd15, 32'h00000001, 1'b0, 32'h0,  1'b0);
    set_row(18, "addi",  32'h00200813, 1'b1, 5'd16, 32'h00000002, 1'b0, 32'h0,  1'b0);
    set_row(19, "or",    32'h00d768b3, 1'b1, 5'd17, 32'h12344fff, 1'b0, 32'h0,  1'b0);
    set_row(20, "and",   32'h00d17933, 1'b1, 5'd18, 32'h12344800, 1'b0, 32'h0,  1'b0);
endtask

/* dv/tb_decode_execute.sv */
/*
 * Testbench for the decode/execute slice, the fetch agent follows o_redirect.
 * Write-backs are matched in order against the rows accepted into ID/EX.
 * Rows must lie at pc = 4 * index starting from 0.
 */

`timescale 1ns/1ns

module tb_decode_execute;

    localparam int NUM_ROWS  = 21;
    localparam int MAX_CYCLE = 3 * NUM_ROWS + 20;

    logic              clk;
    logic              i_arst_n;
    logic              i_valid;
    rv_pkg::word_t     i_instr;
    rv_pkg::word_t     i_pc;
    logic              i_stall;
    logic              o_redirect;
    rv_pkg::word_t     o_redirect_pc;
    logic              o_wb_valid;
    rv_pkg::reg_addr_t o_wb_rd;
    rv_pkg::word_t     o_wb_data;

    string             tbl_name     [NUM_ROWS];
    logic [31:0]       tbl_instr    [NUM_ROWS];
    bit                tbl_has_wb   [NUM_ROWS];
    logic [4:0]        tbl_rd       [NUM_ROWS];
    logic [31:0]       tbl_val      [NUM_ROWS];
    bit                tbl_redir    [NUM_ROWS];
    logic [31:0]       tbl_tgt      [NUM_ROWS];
    bit                tbl_stall    [NUM_ROWS];
    bit                forced_done  [NUM_ROWS];
    bit                row_bad      [NUM_ROWS];

    int                sb_q [$];      // Rows waiting for their write-back
    integer            seed = 32'hc727;
    int                fetch_pc;
    int                cur_row;
    int                ex_row;
    int                wb_row;        // Row that moved into EX/WB at the last edge
    bit                fetch_done;
    bit                wb_loaded;
    bit                seen_redirect;
    logic [31:0]       seen_target;
    logic              last_wb_valid;
    rv_pkg::reg_addr_t last_wb_rd;
    rv_pkg::word_t     last_wb_data;
    bit                drained;
    int                errors;
    int                tests;
    int                cycle_cnt;

    decode_execute_top u_dut (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_valid       (i_valid),
        .i_instr       (i_instr),
        .i_pc          (i_pc),
        .i_stall       (i_stall),
        .o_redirect    (o_redirect),
        .o_redirect_pc (o_redirect_pc),
        .o_wb_valid    (o_wb_valid),
        .o_wb_rd       (o_wb_rd),
        .o_wb_data     (o_wb_data)
    );

    task automatic set_row(input int idx, input string name, input logic [31:0] instr,
                           input bit has_wb, input logic [4:0] rd, input logic [31:0] val,
                           input bit redir, input logic [31:0] tgt, input bit stall);
        tbl_name[idx]   = name;
        tbl_instr[idx]  = instr;
        tbl_has_wb[idx] = has_wb;
        tbl_rd[idx]     = rd;
        tbl_val[idx]    = val;
        tbl_redir[idx]  = redir;
        tbl_tgt[idx]    = tgt;
        tbl_stall[idx]  = stall;
    endtask

    `include "tb_program_table.svh"

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Fetch agent and acceptance bookkeeping
    always @(posedge clk) begin
        if (i_arst_n) begin
            if (!i_stall) begin
                wb_row = ex_row;
                if (i_valid && !seen_redirect) begin
                    ex_row = cur_row;
                    if (tbl_has_wb[cur_row]) begin
                        sb_q.push_back(cur_row);
                    end
                end else begin
                    ex_row = -1;    // Bubble or squashed slot
                end
                if (seen_redirect) begin
                    fetch_pc = seen_target;
                end else if (i_valid) begin
                    fetch_pc = fetch_pc + 4;
                end
            end
            wb_loaded = !i_stall;
            if (fetch_pc >= NUM_ROWS * 4) begin
                fetch_done = 1'b1;
                i_valid    <= 1'b0;
                i_instr    <= 32'h00000013;
                i_stall    <= 1'b0;
            end else begin
                cur_row = fetch_pc / 4;
                i_valid <= 1'b1;
                i_instr <= tbl_instr[cur_row];
                i_pc    <= fetch_pc;
                if (tbl_stall[cur_row] && !forced_done[cur_row]) begin
                    forced_done[cur_row] = 1'b1;
                    i_stall <= 1'b1;
                end else begin
                    i_stall <= (($random(seed) & 7) == 0);
                end
            end
        end
    end

    // Checks at the falling edge, where outputs are settled
    always @(negedge clk) begin
        int row;
        if (i_arst_n) begin
            seen_redirect = o_redirect;
            seen_target   = o_redirect_pc;
            if (!wb_loaded && (o_wb_valid !== last_wb_valid || o_wb_rd !== last_wb_rd ||
                               o_wb_data !== last_wb_data)) begin
                $display("** Error @%0t: EX/WB output changed during a stall", $time);
                errors++;
            end
            last_wb_valid = o_wb_valid;
            last_wb_rd    = o_wb_rd;
            last_wb_data  = o_wb_data;
            if (wb_loaded && o_wb_valid) begin
                if (sb_q.size() == 0) begin
                    $display("** Error @%0t: write-back to x%0d with no instruction pending",
                             $time, o_wb_rd);
                    errors++;
                end else begin
                    row = sb_q.pop_front();
                    if (row != wb_row) begin
                        $display("** Error @%0t: row %0d %s written back in the wrong cycle",
                                 $time, row, tbl_name[row]);
                        row_bad[row] = 1'b1;
                        errors++;
                    end
                    if (o_wb_rd != tbl_rd[row] || o_wb_data != tbl_val[row]) begin
                        $display("** Error @%0t: row %0d %s wrote x%0d=%h, expected x%0d=%h",
                                 $time, row, tbl_name[row], o_wb_rd, o_wb_data,
                                 tbl_rd[row], tbl_val[row]);
                        row_bad[row] = 1'b1;
                        errors++;
                    end
                    $display("row %0d %s: %s", row, tbl_name[row], row_bad[row] ? "FAIL" : "ok");
                    tests++;
                end
            end else if (wb_loaded && wb_row >= 0 && tbl_has_wb[wb_row]) begin
                $display("** Error @%0t: row %0d %s left EX with no write-back",
                         $time, wb_row, tbl_name[wb_row]);
                row_bad[wb_row] = 1'b1;
                errors++;
            end
            if (!i_stall) begin
                if (ex_row >= 0) begin
                    if (o_redirect != tbl_redir[ex_row] ||
                        (tbl_redir[ex_row] && o_redirect_pc != tbl_tgt[ex_row])) begin
                        $display("** Error @%0t: row %0d %s redir=%0b/%0d, expected %0b/%0d",
                                 $time, ex_row, tbl_name[ex_row], o_redirect, o_redirect_pc,
                                 tbl_redir[ex_row], tbl_tgt[ex_row]);
                        row_bad[ex_row] = 1'b1;
                        errors++;
                    end
                    if (!tbl_has_wb[ex_row]) begin
                        $display("row %0d %s: %s", ex_row, tbl_name[ex_row],
                                 row_bad[ex_row] ? "FAIL" : "ok");
                        tests++;
                    end
                end else if (o_redirect) begin
                    $display("** Error @%0t: redirect raised by a bubble", $time);
                    errors++;
                end
            end
            drained = fetch_done && ex_row < 0 && sb_q.size() == 0;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLE) begin
            $display("Timeout after %0d cycles, %0d write-backs still pending",
                     cycle_cnt, sb_q.size());
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        i_arst_n      = 1'b0;
        i_valid       = 1'b0;
        i_instr       = 32'h00000013;
        i_pc          = '0;
        i_stall       = 1'b0;
        fetch_pc      = 0;
        cur_row       = 0;
        ex_row        = -1;
        wb_row        = -1;
        fetch_done    = 1'b0;
        wb_loaded     = 1'b1;     // EX/WB data loads through reset
        seen_redirect = 1'b0;
        seen_target   = '0;
        last_wb_valid = 1'b0;
        drained       = 1'b0;
        errors        = 0;
        tests         = 0;
        cycle_cnt     = 0;
        load_program_table();
        repeat (3) @(posedge clk);
        i_arst_n <= 1'b1;
        wait (drained);
        $display("Tests: %0d finished, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+verilog
+incdir+dv
verilog/rv_pkg.sv
verilog/reg_file.sv
verilog/instr_decoder.sv
verilog/id_ex_reg.sv
verilog/execute_unit.sv
verilog/decode_execute_top.sv
dv/tb_decode_execute.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the decode/execute testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_decode_execute

output=$(./obj_dir/Vtb_decode_execute)
echo "$output"

grep -q "Simulation completed successfully" <<< "$output"
